/* operand_fwd.f */
+incdir+logic
logic/fwd_pkg.sv
logic/operand_forwarding.sv
logic/dest_pipe.sv
logic/exe_operand_mux.sv
logic/fwd_top.sv
verif/fwd_properties.sv
verif/fwd_tb.sv

/* Makefile */
TOOL     = verilator
FLAGS    = --binary --assert -j 0
TOP      = fwd_tb
FILELIST = operand_fwd.f
LOG      = sim.log
FAIL_MSG = Something failed

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then exit 1; fi

clean:
	rm -rf obj_dir $(LOG)

/* verif/fwd_cases.txt */
# in: rs1d rs2d rs3d asel bsel rs1e rs2e rs3e rde we ld mul rdd rdpd rs1v rs2v rs3v ldd ldpd dcst
# out: sel1d sel2d sel3d afwd bfwd cfwd op_a op_b op_c store hazard, all hex
# in rs1v/rs2v a dash is a random word, in op_a/op_b an rf expects the driven word
5 0 0 0 0 1 2 3 5 1 0 0 50 51 - - 33 0 0 0 1 1 1 0 0 0 rf rf 33 0 0
5 0 0 1 1 5 6 7 6 1 0 0 60 61 - - 44 0 0 0 1 1 1 1 1 0 50 rf 44 33 0
5 6 5 0 0 5 6 0 5 3 0 0 70 71 - - 55 0 0 0 1 1 1 2 0 1 50 60 55 44 0
6 7 6 0 0 6 5 6 1f 3 0 0 80 81 - - 66 0 0 0 1 1 1 2 0 1 71 70 71 55 0
6 5 0 0 1 0 6 1f 2 1 0 0 90 91 - - 77 0 0 0 3 1 1 2 1 0 rf 71 80 71 0
0 1f 0 0 0 2 0 0 9 1 1 0 0 0 - - 88 0 0 0 1 1 1 0 2 0 90 rf 88 80 0
2 3 0 0 0 9 2 0 a 1 0 0 a0 a1 111 222 99 123 124 0 1 1 1 2 0 0 0 90 99 88 1
9 3 0 0 0 9 2 0 a 1 0 0 a0 a1 111 222 99 123 124 0 1 1 1 2 0 0 123 rf 99 88 0
0 0 0 0 0 a 0 0 c 1 0 1 120 121 - - 11 0 0 0 1 1 1 0 0 0 a0 rf 11 99 0
0 0 a 0 0 0 c a d 1 0 0 130 131 333 444 22 0 0 0 1 1 1 0 0 1 rf 120 a0 11 1
0 c 0 0 0 0 c a d 1 0 0 130 131 333 444 22 0 0 0 1 1 1 0 2 0 rf 120 22 11 0
0 0 0 0 0 0 0 0 e 3 1 0 0 0 - - 33 0 0 0 1 1 1 0 0 0 rf rf 33 22 0
0 0 0 0 0 0 0 f 0 0 0 0 0 0 - - 44 140 141 0 1 1 1 0 0 0 rf rf 0 33 0
f 0 0 0 0 e f 0 10 1 0 0 160 161 111 222 55 140 141 1 3 1 1 2 0 0 140 141 55 141 1
f 0 0 0 0 e f 0 10 1 0 0 160 161 111 222 55 999 998 1 3 1 1 2 0 0 140 141 55 141 1
e 0 0 1 0 e f 0 10 1 0 0 160 161 111 222 55 999 998 0 1 1 1 1 0 0 140 141 55 141 0
0 0 0 0 0 10 0 0 0 0 0 0 0 0 - - 0 0 0 0 1 1 1 0 0 0 160 rf 0 55 0
11 0 0 0 0 10 0 0 0 0 0 0 0 0 - - 0 0 0 0 1 1 1 0 0 0 160 rf 0 0 0

/* verif/fwd_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module fwd_tb;

    logic clk;
    logic rst_n;
    fwd_pkg::rf_addr_t rs1_dec, rs2_dec, rs3_dec;
    fwd_pkg::a_sel_t a_sel_dec;
    fwd_pkg::b_sel_t b_sel_dec;
    fwd_pkg::rf_addr_t rs1_exe, rs2_exe, rs3_exe, rd_exe;
    fwd_pkg::rf_we_t rf_we_exe;
    logic load_exe, mult_exe, dc_stalled;
    fwd_pkg::data_t exe_rd_data, exe_rdp_data;
    fwd_pkg::data_t rs1_data_exe, rs2_data_exe, rs3_data_exe;
    fwd_pkg::data_t load_rd_data, load_rdp_data;
    fwd_pkg::fwd_be_t fwd_src_sel_rs1_dec, fwd_src_sel_rs2_dec, fwd_src_sel_rs3_dec;
    fwd_pkg::a_sel_t a_sel_dec_fwd;
    fwd_pkg::b_sel_t b_sel_dec_fwd;
    logic c_sel_dec_fwd, hazard_to_exe;
    fwd_pkg::data_t op_a_exe, op_b_exe, op_c_exe, store_data_mem;

    // raw case lines and the fields of the current one
    string case_lines[$];
    string fields[$];
    logic cases_loaded = 1'b0;

    fwd_top dut (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // ------------------------------------------------------------------
    // helpers
    // ------------------------------------------------------------------

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("Something failed");
        $fatal(1, "run aborted");
    endtask

    task automatic split_line(input string line);
        int start;
        start = -1;
        fields.delete();
        for (int i = 0; i <= line.len(); i++) begin
            if (i == line.len() || line[i] == " " || line[i] == "\n" || line[i] == "\r") begin
                if (start >= 0)
                    fields.push_back(line.substr(start, i - 1));
                start = -1;
            end else if (start < 0) begin
                start = i;
            end
        end
    endtask

    function automatic logic [31:0] hex_field(input int idx);
        return fields[idx].atohex();
    endfunction

    // a dash asks for a random register-file word
    function automatic fwd_pkg::data_t data_field(input int idx);
        if (fields[idx] == "-")
            return $urandom();
        else
            return hex_field(idx);
    endfunction

    // unforwarded operands must equal the register-file data
    function automatic logic [31:0] expected_operand(input int idx, input fwd_pkg::data_t rf);
        if (fields[idx] == "rf")
            return rf;
        else
            return hex_field(idx);
    endfunction

    task automatic check_value(input int idx, input string name,
                               input logic [31:0] got, input logic [31:0] want);
        assert (got === want)
        else abort_run($sformatf("Fail %s got %h expected %h in case %0d",
                                 name, got, want, idx + 1));
    endtask

    task automatic init_inputs();
        rst_n = 1'b0;
        {rs1_dec, rs2_dec, rs3_dec, a_sel_dec, b_sel_dec} = '0;
        {rs1_exe, rs2_exe, rs3_exe, rd_exe, rf_we_exe} = '0;
        {load_exe, mult_exe, dc_stalled} = '0;
        {exe_rd_data, exe_rdp_data, rs1_data_exe, rs2_data_exe, rs3_data_exe} = '0;
        {load_rd_data, load_rdp_data} = '0;
    endtask

    task automatic load_cases();
        int fd;
        string line;
        fd = $fopen("verif/fwd_cases.txt", "r");
        if (fd == 0) begin
            abort_run("Could not open the case file verif/fwd_cases.txt");
        end else begin
            while (!$feof(fd)) begin
                line = "";
                void'($fgets(line, fd));
                if (line.len() > 1 && line[0] != "#")
                    case_lines.push_back(line);
            end
            $fclose(fd);
            if (case_lines.size() == 0)
                abort_run("The case file holds no cases");
            else
                cases_loaded = 1'b1;
        end
    endtask

    // ------------------------------------------------------------------
    // per cycle drive and check
    // ------------------------------------------------------------------

    task automatic apply_case(input int idx);
        split_line(case_lines[idx]);
        if (fields.size() != 31) begin
            abort_run($sformatf("Case %0d does not hold 31 fields", idx + 1));
        end else begin
            rs1_dec       = fwd_pkg::rf_addr_t'(hex_field(0));
            rs2_dec       = fwd_pkg::rf_addr_t'(hex_field(1));
            rs3_dec       = fwd_pkg::rf_addr_t'(hex_field(2));
            a_sel_dec     = fwd_pkg::a_sel_t'(hex_field(3));
            b_sel_dec     = fwd_pkg::b_sel_t'(hex_field(4));
            rs1_exe       = fwd_pkg::rf_addr_t'(hex_field(5));
            rs2_exe       = fwd_pkg::rf_addr_t'(hex_field(6));
            rs3_exe       = fwd_pkg::rf_addr_t'(hex_field(7));
            rd_exe        = fwd_pkg::rf_addr_t'(hex_field(8));
            rf_we_exe     = fwd_pkg::rf_we_t'(hex_field(9));
            load_exe      = 1'(hex_field(10));
            mult_exe      = 1'(hex_field(11));
            exe_rd_data   = hex_field(12);
            exe_rdp_data  = hex_field(13);
            rs1_data_exe  = data_field(14);
            rs2_data_exe  = data_field(15);
            rs3_data_exe  = hex_field(16);
            load_rd_data  = hex_field(17);
            load_rdp_data = hex_field(18);
            dc_stalled    = 1'(hex_field(19));
        end
    endtask

    task automatic check_case(input int idx);
        check_value(idx, "fwd_src_sel_rs1_dec", 32'(fwd_src_sel_rs1_dec), hex_field(20));
        check_value(idx, "fwd_src_sel_rs2_dec", 32'(fwd_src_sel_rs2_dec), hex_field(21));
        check_value(idx, "fwd_src_sel_rs3_dec", 32'(fwd_src_sel_rs3_dec), hex_field(22));
        check_value(idx, "a_sel_dec_fwd", 32'(a_sel_dec_fwd), hex_field(23));
        check_value(idx, "b_sel_dec_fwd", 32'(b_sel_dec_fwd), hex_field(24));
        check_value(idx, "c_sel_dec_fwd", 32'(c_sel_dec_fwd), hex_field(25));
        check_value(idx, "op_a_exe", op_a_exe, expected_operand(26, rs1_data_exe));
        check_value(idx, "op_b_exe", op_b_exe, expected_operand(27, rs2_data_exe));
        check_value(idx, "op_c_exe", op_c_exe, expected_operand(28, rs3_data_exe));
        check_value(idx, "store_data_mem", store_data_mem, hex_field(29));
        check_value(idx, "hazard_to_exe", 32'(hazard_to_exe), hex_field(30));
    endtask

    initial begin
        void'($urandom(32'hf72f8e9c));
        init_inputs();
        load_cases();
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        for (int i = 0; i < case_lines.size(); i++) begin
            apply_case(i);
            // just ahead of the rising edge
            #4;
            check_case(i);
            @(negedge clk);
        end
        $display("Everything OK");
        $finish;
    end

    // one clock per case plus reset and slack
    initial begin
        wait (cases_loaded);
        #(case_lines.size() * 10 + 200);
        abort_run("Watchdog expired before all cases were run");
    end

endmodule

`default_nettype wire

/* verif/fwd_properties.sv */
`timescale 1ns/1ps
`default_nettype none

module fwd_properties (
    input wire logic clk,
    input wire logic rst_n,
    input wire logic dc_stalled,
    input wire logic hazard_to_exe,
    input wire fwd_pkg::rf_we_t rf_we_mem,
    input wire fwd_pkg::rf_we_t rf_we_wbk,
    input wire fwd_pkg::rf_addr_t rd_wbk,
    input wire logic load_inst_wbk,
    input wire fwd_pkg::data_t wbk_rd_data,
    input wire fwd_pkg::data_t wbk_rdp_data
);

    // nothing writes the register file out of reset
    reset_clears_we: assert property (@(posedge clk)
        !rst_n |=> (rf_we_mem == '0) && (rf_we_wbk == '0))
        else $error("write enables still set one cycle into reset");

    // held execute leaves a bubble behind in memory
    hazard_inserts_bubble: assert property (@(posedge clk) disable iff (!rst_n)
        hazard_to_exe && !dc_stalled |=> (rf_we_mem == '0))
        else $error("memory stage got a write after a hazard cycle");

    // cache stall freezes writeback
    stall_holds_wbk: assert property (@(posedge clk) disable iff (!rst_n)
        dc_stalled |=> $stable(rd_wbk) && $stable(rf_we_wbk) && $stable(load_inst_wbk)
            && $stable(wbk_rd_data) && $stable(wbk_rdp_data))
        else $error("writeback stage moved during a cache stall");

endmodule

bind dest_pipe fwd_properties u_fwd_properties (.*);

`default_nettype wire

/* logic/fwd_top.sv */
`timescale 1ns/1ps
`default_nettype none

module fwd_top (
    input  logic clk,
    input  logic rst_n,
    // decode
    input  fwd_pkg::rf_addr_t rs1_dec,
    input  fwd_pkg::rf_addr_t rs2_dec,
    input  fwd_pkg::rf_addr_t rs3_dec,
    input  fwd_pkg::a_sel_t a_sel_dec,
    input  fwd_pkg::b_sel_t b_sel_dec,
    // execute
    input  fwd_pkg::rf_addr_t rs1_exe,
    input  fwd_pkg::rf_addr_t rs2_exe,
    input  fwd_pkg::rf_addr_t rs3_exe,
    input  fwd_pkg::rf_addr_t rd_exe,
    input  fwd_pkg::rf_we_t rf_we_exe,
    input  logic load_exe,
    input  logic mult_exe,
    input  fwd_pkg::data_t exe_rd_data,
    input  fwd_pkg::data_t exe_rdp_data,
    input  fwd_pkg::data_t rs1_data_exe,
    input  fwd_pkg::data_t rs2_data_exe,
    input  fwd_pkg::data_t rs3_data_exe,
    // memory and data cache
    input  fwd_pkg::data_t load_rd_data,
    input  fwd_pkg::data_t load_rdp_data,
    input  logic dc_stalled,
    // results
    output fwd_pkg::fwd_be_t fwd_src_sel_rs1_dec,
    output fwd_pkg::fwd_be_t fwd_src_sel_rs2_dec,
    output fwd_pkg::fwd_be_t fwd_src_sel_rs3_dec,
    output fwd_pkg::a_sel_t a_sel_dec_fwd,
    output fwd_pkg::b_sel_t b_sel_dec_fwd,
    output logic c_sel_dec_fwd,
    output fwd_pkg::data_t op_a_exe,
    output fwd_pkg::data_t op_b_exe,
    output fwd_pkg::data_t op_c_exe,
    output fwd_pkg::data_t store_data_mem,
    output logic hazard_to_exe
);

    // ------------------------------------------------------------------
    // memory and writeback stage state
    // ------------------------------------------------------------------

    wire fwd_pkg::rf_addr_t rd_mem;
    wire fwd_pkg::rf_we_t rf_we_mem;
    wire fwd_pkg::rf_addr_t rs3_mem;
    wire logic load_inst_mem;
    wire logic mult_inst_mem;
    wire fwd_pkg::data_t mem_rd_data;
    wire fwd_pkg::data_t mem_rdp_data;
    wire fwd_pkg::data_t rs3_data_mem;
    wire fwd_pkg::rf_addr_t rd_wbk;
    wire fwd_pkg::rf_we_t rf_we_wbk;
    wire logic load_inst_wbk;
    wire fwd_pkg::data_t wbk_rd_data;
    wire fwd_pkg::data_t wbk_rdp_data;

    // selects for the execute and store data muxes
    wire fwd_pkg::fwd_be_t fwd_src_sel_rs1_exe;
    wire fwd_pkg::fwd_be_t fwd_src_sel_rs2_exe;
    wire fwd_pkg::fwd_be_t fwd_src_sel_rs3_exe;
    wire fwd_pkg::fwd_be_t fwd_src_sel_rs3_mem;
    wire logic a_sel_fwd_exe;
    wire logic b_sel_fwd_exe;
    wire logic c_sel_fwd_exe;
    wire logic c_sel_fwd_mem;

    // ------------------------------------------------------------------
    // pipe, forwarding unit and operand mux
    // ------------------------------------------------------------------

    dest_pipe u_dest_pipe (.*);

    operand_forwarding u_operand_forwarding (.*);

    exe_operand_mux u_exe_operand_mux (.*);

endmodule

`default_nettype wire

/* logic/exe_operand_mux.sv */
`timescale 1ns/1ps
`default_nettype none

`include "fwd_macros.svh"

module exe_operand_mux (
    input  fwd_pkg::fwd_be_t fwd_src_sel_rs1_exe,
    input  fwd_pkg::fwd_be_t fwd_src_sel_rs2_exe,
    input  fwd_pkg::fwd_be_t fwd_src_sel_rs3_exe,
    input  fwd_pkg::fwd_be_t fwd_src_sel_rs3_mem,
    input  logic a_sel_fwd_exe,
    input  logic b_sel_fwd_exe,
    input  logic c_sel_fwd_exe,
    input  logic c_sel_fwd_mem,
    input  fwd_pkg::data_t rs1_data_exe,
    input  fwd_pkg::data_t rs2_data_exe,
    input  fwd_pkg::data_t rs3_data_exe,
    input  fwd_pkg::data_t rs3_data_mem,
    input  fwd_pkg::data_t mem_rd_data,
    input  fwd_pkg::data_t mem_rdp_data,
    input  fwd_pkg::data_t wbk_rd_data,
    input  fwd_pkg::data_t wbk_rdp_data,
    output fwd_pkg::data_t op_a_exe,
    output fwd_pkg::data_t op_b_exe,
    output fwd_pkg::data_t op_c_exe,
    output fwd_pkg::data_t store_data_mem
);

    // one of the four in-flight results
    function automatic fwd_pkg::data_t pick(
        input fwd_pkg::fwd_be_t sel,
        input fwd_pkg::data_t m_rd,
        input fwd_pkg::data_t m_rdp,
        input fwd_pkg::data_t w_rd,
        input fwd_pkg::data_t w_rdp
    );
        case ({sel[`FWD_SRC_WBK], sel[`FWD_SRC_RDP]})
            2'b00:   pick = m_rd;
            2'b01:   pick = m_rdp;
            2'b10:   pick = w_rd;
            default: pick = w_rdp;
        endcase
    endfunction

    // execute operands
    assign op_a_exe = a_sel_fwd_exe ?
        pick(fwd_src_sel_rs1_exe, mem_rd_data, mem_rdp_data, wbk_rd_data, wbk_rdp_data) :
        rs1_data_exe;
    assign op_b_exe = b_sel_fwd_exe ?
        pick(fwd_src_sel_rs2_exe, mem_rd_data, mem_rdp_data, wbk_rd_data, wbk_rdp_data) :
        rs2_data_exe;
    assign op_c_exe = c_sel_fwd_exe ?
        pick(fwd_src_sel_rs3_exe, mem_rd_data, mem_rdp_data, wbk_rd_data, wbk_rdp_data) :
        rs3_data_exe;

    // store data select always points at writeback here
    assign store_data_mem = c_sel_fwd_mem ?
        pick(fwd_src_sel_rs3_mem, mem_rd_data, mem_rdp_data, wbk_rd_data, wbk_rdp_data) :
        rs3_data_mem;

endmodule

`default_nettype wire

/* logic/dest_pipe.sv */
`timescale 1ns/1ps
`default_nettype none

module dest_pipe (
    input  logic clk,
    input  logic rst_n,
    input  logic dc_stalled,
    input  logic hazard_to_exe,
    input  fwd_pkg::rf_addr_t rd_exe,
    input  fwd_pkg::rf_we_t rf_we_exe,
    input  fwd_pkg::rf_addr_t rs3_exe,
    input  logic load_exe,
    input  logic mult_exe,
    input  fwd_pkg::data_t exe_rd_data,
    input  fwd_pkg::data_t exe_rdp_data,
    input  fwd_pkg::data_t rs3_data_exe,
    input  fwd_pkg::data_t load_rd_data,
    input  fwd_pkg::data_t load_rdp_data,
    output fwd_pkg::rf_addr_t rd_mem,
    output fwd_pkg::rf_we_t rf_we_mem,
    output fwd_pkg::rf_addr_t rs3_mem,
    output logic load_inst_mem,
    output logic mult_inst_mem,
    output fwd_pkg::data_t mem_rd_data,
    output fwd_pkg::data_t mem_rdp_data,
    output fwd_pkg::data_t rs3_data_mem,
    output fwd_pkg::rf_addr_t rd_wbk,
    output fwd_pkg::rf_we_t rf_we_wbk,
    output logic load_inst_wbk,
    output fwd_pkg::data_t wbk_rd_data,
    output fwd_pkg::data_t wbk_rdp_data
);

    // ------------------------------------------------------------------
    // execute to memory
    // ------------------------------------------------------------------

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rd_mem        <= '0;
            rf_we_mem     <= '0;
            rs3_mem       <= '0;
            load_inst_mem <= 1'b0;
            mult_inst_mem <= 1'b0;
            mem_rd_data   <= '0;
            mem_rdp_data  <= '0;
            rs3_data_mem  <= '0;
        end else if (!dc_stalled) begin
            if (hazard_to_exe) begin
                // bubble while execute stays put
                rf_we_mem     <= '0;
                load_inst_mem <= 1'b0;
                mult_inst_mem <= 1'b0;
            end else begin
                rd_mem        <= rd_exe;
                rf_we_mem     <= rf_we_exe;
                rs3_mem       <= rs3_exe;
                load_inst_mem <= load_exe;
                mult_inst_mem <= mult_exe;
                mem_rd_data   <= exe_rd_data;
                mem_rdp_data  <= exe_rdp_data;
                rs3_data_mem  <= rs3_data_exe;
            end
        end
    end

    // ------------------------------------------------------------------
    // memory to writeback even while execute is held
    // ------------------------------------------------------------------

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rd_wbk        <= '0;
            rf_we_wbk     <= '0;
            load_inst_wbk <= 1'b0;
            wbk_rd_data   <= '0;
            wbk_rdp_data  <= '0;
        end else if (!dc_stalled) begin
            rd_wbk        <= rd_mem;
            rf_we_wbk     <= rf_we_mem;
            load_inst_wbk <= load_inst_mem;
            // loads retire with the cache data
            wbk_rd_data   <= load_inst_mem ? load_rd_data : mem_rd_data;
            wbk_rdp_data  <= load_inst_mem ? load_rdp_data : mem_rdp_data;
        end
    end

endmodule

`default_nettype wire

/* logic/operand_forwarding.sv */
`timescale 1ns/1ps
`default_nettype none

`include "fwd_macros.svh"

module operand_forwarding (
    input  logic load_inst_mem,
    input  logic load_inst_wbk,
    input  logic dc_stalled,
    input  logic mult_inst_mem,
    input  fwd_pkg::rf_addr_t rs1_dec,
    input  fwd_pkg::rf_addr_t rs2_dec,
    input  fwd_pkg::rf_addr_t rs3_dec,
    input  fwd_pkg::rf_addr_t rs1_exe,
    input  fwd_pkg::rf_addr_t rs2_exe,
    input  fwd_pkg::rf_addr_t rs3_exe,
    input  fwd_pkg::rf_addr_t rs3_mem,
    input  fwd_pkg::rf_addr_t rd_mem,
    input  fwd_pkg::rf_addr_t rd_wbk,
    input  fwd_pkg::rf_we_t rf_we_mem,
    input  fwd_pkg::rf_we_t rf_we_wbk,
    input  fwd_pkg::a_sel_t a_sel_dec,
    input  fwd_pkg::b_sel_t b_sel_dec,
    output fwd_pkg::fwd_be_t fwd_src_sel_rs1_dec,
    output fwd_pkg::fwd_be_t fwd_src_sel_rs2_dec,
    output fwd_pkg::fwd_be_t fwd_src_sel_rs3_dec,
    output fwd_pkg::a_sel_t a_sel_dec_fwd,
    output fwd_pkg::b_sel_t b_sel_dec_fwd,
    output logic c_sel_dec_fwd,
    output fwd_pkg::fwd_be_t fwd_src_sel_rs1_exe,
    output fwd_pkg::fwd_be_t fwd_src_sel_rs2_exe,
    output fwd_pkg::fwd_be_t fwd_src_sel_rs3_exe,
    output logic a_sel_fwd_exe,
    output logic b_sel_fwd_exe,
    output logic c_sel_fwd_exe,
    output fwd_pkg::fwd_be_t fwd_src_sel_rs3_mem,
    output logic c_sel_fwd_mem,
    output logic hazard_to_exe
);

    // ------------------------------------------------------------------
    // helpers
    // ------------------------------------------------------------------

    // nonzero source written by the given destination
    function automatic logic hit(
        input fwd_pkg::rf_addr_t rs,
        input fwd_pkg::rf_addr_t rd,
        input logic we
    );
        hit = (rs != '0) && (rs == rd) && we;
    endfunction

    // memory wins for execute sources since it is the younger write
    function automatic fwd_pkg::fwd_be_t exe_sel(
        input logic in_mem,
        input logic mem_rdp,
        input logic wbk_rdp
    );
        fwd_pkg::fwd_be_t sel;
        sel[`FWD_SRC_WBK] = !in_mem;
        sel[`FWD_SRC_RDP] = in_mem ? mem_rdp : wbk_rdp;
        return sel;
    endfunction

    // decode and rs3_mem only ever see writeback
    function automatic fwd_pkg::fwd_be_t wbk_sel(input logic wbk_rdp);
        fwd_pkg::fwd_be_t sel;
        sel[`FWD_SRC_WBK] = 1'b1;
        sel[`FWD_SRC_RDP] = wbk_rdp;
        return sel;
    endfunction

    // paired destinations wrap at 32
    fwd_pkg::rf_addr_t rdp_mem;
    fwd_pkg::rf_addr_t rdp_wbk;

    assign rdp_mem = fwd_pkg::rf_addr_t'(rd_mem + 1'b1);
    assign rdp_wbk = fwd_pkg::rf_addr_t'(rd_wbk + 1'b1);

    // ------------------------------------------------------------------
    // dependency tracking
    // ------------------------------------------------------------------

    // execute sources against memory
    logic rs1_exe_mem_rd, rs1_exe_mem_rdp;
    logic rs2_exe_mem_rd, rs2_exe_mem_rdp;
    logic rs3_exe_mem_rd, rs3_exe_mem_rdp;

    assign rs1_exe_mem_rd  = hit(rs1_exe, rd_mem, rf_we_mem[0]);
    assign rs1_exe_mem_rdp = hit(rs1_exe, rdp_mem, rf_we_mem[1]);
    assign rs2_exe_mem_rd  = hit(rs2_exe, rd_mem, rf_we_mem[0]);
    assign rs2_exe_mem_rdp = hit(rs2_exe, rdp_mem, rf_we_mem[1]);
    assign rs3_exe_mem_rd  = hit(rs3_exe, rd_mem, rf_we_mem[0]);
    assign rs3_exe_mem_rdp = hit(rs3_exe, rdp_mem, rf_we_mem[1]);

    // execute sources against writeback
    logic rs1_exe_wbk_rd, rs1_exe_wbk_rdp;
    logic rs2_exe_wbk_rd, rs2_exe_wbk_rdp;
    logic rs3_exe_wbk_rd, rs3_exe_wbk_rdp;

    assign rs1_exe_wbk_rd  = hit(rs1_exe, rd_wbk, rf_we_wbk[0]);
    assign rs1_exe_wbk_rdp = hit(rs1_exe, rdp_wbk, rf_we_wbk[1]);
    assign rs2_exe_wbk_rd  = hit(rs2_exe, rd_wbk, rf_we_wbk[0]);
    assign rs2_exe_wbk_rdp = hit(rs2_exe, rdp_wbk, rf_we_wbk[1]);
    assign rs3_exe_wbk_rd  = hit(rs3_exe, rd_wbk, rf_we_wbk[0]);
    assign rs3_exe_wbk_rdp = hit(rs3_exe, rdp_wbk, rf_we_wbk[1]);

    // decode sources and store data against writeback only
    logic rs1_dec_wbk_rd, rs1_dec_wbk_rdp;
    logic rs2_dec_wbk_rd, rs2_dec_wbk_rdp;
    logic rs3_dec_wbk_rd, rs3_dec_wbk_rdp;
    logic rs3_mem_wbk_rd, rs3_mem_wbk_rdp;

    assign rs1_dec_wbk_rd  = hit(rs1_dec, rd_wbk, rf_we_wbk[0]);
    assign rs1_dec_wbk_rdp = hit(rs1_dec, rdp_wbk, rf_we_wbk[1]);
    assign rs2_dec_wbk_rd  = hit(rs2_dec, rd_wbk, rf_we_wbk[0]);
    assign rs2_dec_wbk_rdp = hit(rs2_dec, rdp_wbk, rf_we_wbk[1]);
    assign rs3_dec_wbk_rd  = hit(rs3_dec, rd_wbk, rf_we_wbk[0]);
    assign rs3_dec_wbk_rdp = hit(rs3_dec, rdp_wbk, rf_we_wbk[1]);
    assign rs3_mem_wbk_rd  = hit(rs3_mem, rd_wbk, rf_we_wbk[0]);
    assign rs3_mem_wbk_rdp = hit(rs3_mem, rdp_wbk, rf_we_wbk[1]);

    // found anywhere in the stage
    logic rs1_exe_in_mem, rs2_exe_in_mem, rs3_exe_in_mem;
    logic rs1_exe_in_wbk, rs2_exe_in_wbk, rs3_exe_in_wbk;
    logic rs1_dec_in_wbk, rs2_dec_in_wbk, rs3_dec_in_wbk;
    logic rs3_mem_in_wbk;

    assign rs1_exe_in_mem = rs1_exe_mem_rd || rs1_exe_mem_rdp;
    assign rs2_exe_in_mem = rs2_exe_mem_rd || rs2_exe_mem_rdp;
    assign rs3_exe_in_mem = rs3_exe_mem_rd || rs3_exe_mem_rdp;
    assign rs1_exe_in_wbk = rs1_exe_wbk_rd || rs1_exe_wbk_rdp;
    assign rs2_exe_in_wbk = rs2_exe_wbk_rd || rs2_exe_wbk_rdp;
    assign rs3_exe_in_wbk = rs3_exe_wbk_rd || rs3_exe_wbk_rdp;
    assign rs1_dec_in_wbk = rs1_dec_wbk_rd || rs1_dec_wbk_rdp;
    assign rs2_dec_in_wbk = rs2_dec_wbk_rd || rs2_dec_wbk_rdp;
    assign rs3_dec_in_wbk = rs3_dec_wbk_rd || rs3_dec_wbk_rdp;
    assign rs3_mem_in_wbk = rs3_mem_wbk_rd || rs3_mem_wbk_rdp;

    // ------------------------------------------------------------------
    // source selects and forward flags
    // ------------------------------------------------------------------

    assign fwd_src_sel_rs1_exe = exe_sel(rs1_exe_in_mem, rs1_exe_mem_rdp, rs1_exe_wbk_rdp);
    assign fwd_src_sel_rs2_exe = exe_sel(rs2_exe_in_mem, rs2_exe_mem_rdp, rs2_exe_wbk_rdp);
    assign fwd_src_sel_rs3_exe = exe_sel(rs3_exe_in_mem, rs3_exe_mem_rdp, rs3_exe_wbk_rdp);

    assign fwd_src_sel_rs1_dec = wbk_sel(rs1_dec_wbk_rdp);
    assign fwd_src_sel_rs2_dec = wbk_sel(rs2_dec_wbk_rdp);
    assign fwd_src_sel_rs3_dec = wbk_sel(rs3_dec_wbk_rdp);
    assign fwd_src_sel_rs3_mem = wbk_sel(rs3_mem_wbk_rdp);

    assign a_sel_fwd_exe = rs1_exe_in_mem || rs1_exe_in_wbk;
    assign b_sel_fwd_exe = rs2_exe_in_mem || rs2_exe_in_wbk;
    assign c_sel_fwd_exe = rs3_exe_in_mem || rs3_exe_in_wbk;
    assign c_sel_fwd_mem = rs3_mem_in_wbk;

    // pc and immediate selects are left alone
    assign a_sel_dec_fwd = (rs1_dec_in_wbk && (a_sel_dec == `A_SEL_RS1)) ?
        `A_SEL_FWD : a_sel_dec;
    assign b_sel_dec_fwd = (rs2_dec_in_wbk && (b_sel_dec == `B_SEL_RS2)) ?
        `B_SEL_FWD : b_sel_dec;
    assign c_sel_dec_fwd = rs3_dec_in_wbk;

    // ------------------------------------------------------------------
    // hazard on results not ready yet
    // ------------------------------------------------------------------

    logic late_in_mem;
    logic late_in_wbk;

    // load or multiply data shows up only at the end of memory
    assign late_in_mem = load_inst_mem || mult_inst_mem;
    assign late_in_wbk = load_inst_wbk && dc_stalled;

    assign hazard_to_exe =
        (late_in_mem && (rs1_exe_in_mem || rs2_exe_in_mem)) ||
        (late_in_wbk && (rs1_exe_in_wbk || rs2_exe_in_wbk));

endmodule

`default_nettype wire

/* logic/fwd_pkg.sv */
`default_nettype none

`include "fwd_macros.svh"

package fwd_pkg;

    // ------------------------------------------------------------------
    // data and register numbers
    // ------------------------------------------------------------------

    // one result or operand word
    typedef logic [`FWD_XLEN-1:0] data_t;

    // register number where x0 reads as zero and is never forwarded
    typedef logic [`FWD_RF_AW-1:0] rf_addr_t;

    // write enables per stage
    // bit 0 is the rd write and bit 1 the paired rd + 1 write
    typedef logic [1:0] rf_we_t;

    // ------------------------------------------------------------------
    // forwarding selects
    // ------------------------------------------------------------------

    // source of a forwarded value
    // FWD_SRC_WBK set means writeback and clear means memory
    // FWD_SRC_RDP set means the paired register result
    typedef logic [1:0] fwd_be_t;

    // decode operand selects in the A_SEL and B_SEL encodings
    typedef logic [1:0] a_sel_t;
    typedef logic [1:0] b_sel_t;

endpackage

`default_nettype wire

/* logic/fwd_macros.svh */
`ifndef FWD_MACROS_SVH
`define FWD_MACROS_SVH

// datapath and register file sizes
`define FWD_XLEN 32
`define FWD_RF_AW 5

// a operand select in decode
`define A_SEL_RS1 2'd0
`define A_SEL_PC 2'd1
`define A_SEL_FWD 2'd2

// b operand select in decode
`define B_SEL_RS2 2'd0
`define B_SEL_IMM 2'd1
`define B_SEL_FWD 2'd2

// bit positions inside fwd_be_t
`define FWD_SRC_WBK 0
`define FWD_SRC_RDP 1

`endif
